/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := verilog.f
OBJDIR    := obj_dir
RUNFLAGS  := +verilator+error+limit+10

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(OBJDIR)

/* branch_predecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module branch_predecode (
   input  logic [63:0]         cur_pc,
   input  fetch_pkg::rv_inst_u cur_inst,
   output logic [63:0]         pred_next_pc
);

   logic [63:0] j_imm;
   logic [63:0] b_imm;
   logic        is_jal;
   logic        is_branch;
   logic        b_back;

   // j immediate, sign from bit 31
   assign j_imm = {{44{cur_inst.j_fmt.imm20}},
                   cur_inst.j_fmt.imm19_12,
                   cur_inst.j_fmt.imm11,
                   cur_inst.j_fmt.imm10_1,
                   1'b0};

   // b immediate, same sign bit position
   assign b_imm = {{52{cur_inst.b_fmt.imm12}},
                   cur_inst.b_fmt.imm11,
                   cur_inst.b_fmt.imm10_5,
                   cur_inst.b_fmt.imm4_1,
                   1'b0};

   assign is_jal = (cur_inst.j_fmt.opcode == `OP_JAL);
   // funct3 2 and 3 are not branches
   assign is_branch = (cur_inst.b_fmt.opcode == `OP_BRANCH) &&
                      (cur_inst.b_fmt.funct3[2:1] != 2'b01);
   // backward taken, forward falls through
   assign b_back = cur_inst.b_fmt.imm12;

   always_comb begin
      if (is_jal) begin
         pred_next_pc = cur_pc + j_imm;
      end else if (is_branch && b_back) begin
         pred_next_pc = cur_pc + b_imm;
      end else begin
         pred_next_pc = cur_pc + 64'd4;
      end
   end

endmodule

`default_nettype wire

/* fetch_asserts.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_asserts (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  hold,
   input logic                  arvalid,
   input logic                  arready,
   input fetch_pkg::fetch_req_s req,
   input logic                  rvalid,
   input logic                  out_valid,
   input logic                  halted
);

   // sticky, one per property
   logic bad_req = 1'b0;
   logic bad_hold = 1'b0;
   logic bad_lat = 1'b0;
   logic bad_strobe = 1'b0;
   logic bad_halt = 1'b0;
   logic any_fail;

   assign any_fail = bad_req | bad_hold | bad_lat | bad_strobe | bad_halt;

   // request stays up and stable until taken
   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(req))
      else begin
         bad_req = 1'b1;
         $error("read request dropped or changed before acceptance");
      end

   // hold blocks any new request
   hold_blocks: assert property (@(posedge clk) disable iff (!rst_n)
      hold && !arvalid |=> !arvalid)
      else begin
         bad_hold = 1'b1;
         $error("new read request started while hold was high");
      end

   // fixed memory latency, response one edge after the fire edge
   read_latency: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && arready |-> ##(`IMEM_LATENCY + 1) rvalid)
      else begin
         bad_lat = 1'b1;
         $error("read response missing at the fixed latency");
      end

   // output strobe is one cycle wide
   strobe_width: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |=> !out_valid)
      else begin
         bad_strobe = 1'b1;
         $error("out_valid stayed high for two cycles");
      end

   // nothing leaves a halted unit
   halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> !arvalid)
      else begin
         bad_halt = 1'b1;
         $error("read request issued after a fault");
      end

endmodule

`default_nettype wire

/* fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// pc after reset, base of the on-chip image
`define RESET_PC      64'h0000_0000_8000_0000

// image depth in 64-bit words
`define IMEM_WORDS    256

// cycles from accepted request to rvalid
`define IMEM_LATENCY  2

// rv64 opcodes seen by the predecoder
`define OP_JAL        7'b110_1111
`define OP_BRANCH     7'b110_0011

// read response codes, axi style
`define RESP_OKAY     2'b00
`define RESP_SLVERR   2'b10

`endif

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

   // j-type view, imm bits scrambled as in the isa
   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_s;

   // b-type view
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_s;

   // one instruction word, decoded either way
   typedef union packed {
      logic [31:0] raw;
      j_fmt_s      j_fmt;
      b_fmt_s      b_fmt;
   } rv_inst_u;

   // read address channel payload
   typedef struct packed {
      logic [31:0] araddr;
   } fetch_req_s;

   // read data channel payload
   typedef struct packed {
      logic [63:0] rdata;
      logic [1:0]  rresp;
   } fetch_rsp_s;

   // fetched instruction record, 161 bits
   typedef struct packed {
      logic [63:0] pc;
      rv_inst_u    inst;
      logic [63:0] next_pc;
      logic        fault;
   } fetch_out_s;

endpackage

`default_nettype wire

/* fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_tb;
   import fetch_pkg::*;

   localparam int N_STROBES    = 400;
   localparam int QUIET_CYCLES = 50;
   localparam int N_INST       = `IMEM_WORDS * 2;
   localparam int LOAD_CYCLES  = `IMEM_WORDS + 4;
   localparam int MAX_CYCLES   = LOAD_CYCLES + 40 * (N_STROBES + 1) + QUIET_CYCLES;
   // just past the image, word aligned
   localparam logic [63:0] BAD_PC = `RESET_PC + 64'(`IMEM_WORDS * 8) + 64'h40;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        load_valid = 1'b0;
   logic [7:0]  load_addr = '0;
   logic [63:0] load_data = '0;
   logic        hold = 1'b0;
   logic        redirect = 1'b0;
   logic [63:0] redirect_pc = '0;
   logic        out_valid;
   fetch_out_s  out;

   // model state
   logic [31:0] rng_state = 32'h406a_ce58;
   logic [63:0] image [`IMEM_WORDS];
   logic [63:0] exp_pc = `RESET_PC;
   int          n_checked = 0;
   int          hold_run = 0;
   int          cycles = 0;
   logic        fault_seen = 1'b0;

   fetch_top i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_valid  (load_valid),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .hold        (hold),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .out_valid   (out_valid),
      .out         (out)
   );

   bind fetch_unit fetch_asserts u_asserts (
      .clk       (clk),
      .rst_n     (rst_n),
      .hold      (hold),
      .arvalid   (arvalid),
      .arready   (arready),
      .req       (req),
      .rvalid    (rvalid),
      .out_valid (out_valid),
      .halted    (halted)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] rand32();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // isa encoders, offsets in bytes
   function automatic logic [31:0] enc_jal(input logic [31:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
   endfunction

   function automatic logic [31:0] enc_branch(input logic [31:0] off, input logic [2:0] f3,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
   endfunction

   // random word must not jump by accident
   function automatic logic [31:0] scrub(input logic [31:0] inst);
      logic [31:0] v;
      v = inst;
      if (v[6:0] == `OP_JAL || v[6:0] == `OP_BRANCH) begin
         v[6:0] = 7'b001_0011;
      end
      return v;
   endfunction

   // jal or branch at instruction index k, targets kept inside the image
   function automatic logic [31:0] make_flow(input int k, input logic [31:0] r);
      int          delta;
      int          target;
      logic [31:0] off;
      logic [2:0]  f3;
      delta = 1 + int'(r[7:4]);
      f3 = r[16:14];
      // funct3 2 and 3 are not branches
      if (f3[2:1] == 2'b01) begin
         f3 = f3 + 3'd2;
      end
      if (r[1:0] == 2'd0 || r[1:0] == 2'd3) begin
         target = r[8] ? k - delta : k + delta;
         if (target < 0 || target >= N_INST) begin
            target = 2 * k - target;
         end
         off = (target - k) * 4;
         return enc_jal(off, r[13:9]);
      end
      if (r[1:0] == 2'd1 && k >= delta) begin
         off = -delta * 4;
      end else begin
         off = delta * 4;
      end
      return enc_branch(off, f3, r[21:17], r[26:22]);
   endfunction

   task automatic build_image();
      logic [31:0] r;
      logic [31:0] lo;
      logic [31:0] hi;
      int          k;
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         lo = scrub(rand32());
         hi = scrub(rand32());
         image[i] = {hi, lo};
      end
      // about a quarter of the words get control flow
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         r = rand32();
         if (r[1:0] == 2'd0) begin
            k = 2 * i + int'(r[2]);
            if (r[2]) begin
               image[i][63:32] = make_flow(k, rand32());
            end else begin
               image[i][31:0] = make_flow(k, rand32());
            end
         end
      end
      // last slot wraps to the base so pc+4 never leaves the image
      image[`IMEM_WORDS - 1][63:32] = enc_jal(32'(-(N_INST - 1) * 4), 5'd0);
   endtask

   function automatic logic in_image(input logic [63:0] pc);
      logic [63:0] off;
      off = pc - `RESET_PC;
      return (off < 64'(`IMEM_WORDS * 8)) && (pc[1:0] == 2'b00);
   endfunction

   function automatic logic [31:0] inst_at(input logic [63:0] pc);
      logic [63:0] off;
      logic [63:0] word;
      off = pc - `RESET_PC;
      word = image[off[$clog2(`IMEM_WORDS) + 2:3]];
      return pc[2] ? word[63:32] : word[31:0];
   endfunction

   // static prediction from the raw bits
   function automatic logic [63:0] predict(input logic [63:0] pc, input logic [31:0] inst);
      logic [63:0] j_off;
      logic [63:0] b_off;
      logic [2:0]  f3;
      j_off = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      b_off = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      f3 = inst[14:12];
      if (inst[6:0] == `OP_JAL) begin
         return pc + j_off;
      end
      if (inst[6:0] == `OP_BRANCH && f3 != 3'd2 && f3 != 3'd3 && inst[31]) begin
         return pc + b_off;
      end
      return pc + 64'd4;
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         abort_run("timeout, the run went past its cycle limit");
      end
   end

   // strobe checker, sees the values of the cycle that just ended
   always @(posedge clk) begin : strobe_check
      logic [31:0] e_inst;
      logic [63:0] e_next;
      logic        e_fault;
      if (rst_n) begin
         if (hold) begin
            hold_run = hold_run + 1;
         end else begin
            hold_run = 0;
         end
         if (i_dut.u_fetch.u_asserts.any_fail) begin
            abort_run("a bound assertion on the fetch unit failed");
         end
         if (out_valid) begin
            if (fault_seen) begin
               abort_run("instruction strobe after a fault, fetch did not halt");
            end
            // at most the one read in flight when hold rose
            if (hold_run > `IMEM_LATENCY + 3) begin
               abort_run("instruction strobe deep inside a hold window");
            end
            e_fault = !in_image(exp_pc);
            e_inst = e_fault ? 32'h0 : inst_at(exp_pc);
            e_next = predict(exp_pc, e_inst);
            check_value("pc", exp_pc, out.pc);
            check_value("inst", {32'h0, e_inst}, {32'h0, out.inst.raw});
            check_value("next_pc", e_next, out.next_pc);
            check_value("fault", {63'h0, e_fault}, {63'h0, out.fault});
            n_checked <= n_checked + 1;
            if (e_fault) begin
               fault_seen <= 1'b1;
            end
            exp_pc = e_next;
         end
         // redirect applies after any strobe of the same cycle
         if (redirect) begin
            exp_pc = redirect_pc;
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      build_image();
      // image goes in while the core is in reset
      for (int i = 0; i < `IMEM_WORDS; i++) begin
         @(posedge clk);
         load_valid <= 1'b1;
         load_addr  <= 8'(i);
         load_data  <= image[i];
      end
      @(posedge clk);
      load_valid <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      // random hold about 20%, redirect about 1 in 64
      while (n_checked < N_STROBES) begin
         @(posedge clk);
         r = rand32();
         hold        <= (r[7:0] < 8'd51);
         redirect    <= (r[15:10] == 6'd0);
         redirect_pc <= `RESET_PC + {53'h0, r[24:16], 2'b00};
      end
      // out-of-range redirect, expect one fault strobe then silence
      @(posedge clk);
      hold        <= 1'b0;
      redirect    <= 1'b1;
      redirect_pc <= BAD_PC;
      @(posedge clk);
      redirect <= 1'b0;
      while (!fault_seen) begin
         @(posedge clk);
      end
      repeat (QUIET_CYCLES) @(posedge clk);
      // checks of the last edge are done by the falling edge
      @(negedge clk);
      if (!i_dut.u_fetch.u_asserts.any_fail) begin
         $display("Regression passed");
         $finish;
      end else begin
         abort_run("a bound assertion on the fetch unit failed");
      end
   end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load_valid,
   input  logic [7:0]            load_addr,
   input  logic [63:0]           load_data,
   input  logic                  hold,
   input  logic                  redirect,
   input  logic [63:0]           redirect_pc,
   output logic                  out_valid,
   output fetch_pkg::fetch_out_s out
);
   import fetch_pkg::*;

   // read channels
   logic        arvalid;
   logic        arready;
   logic        rvalid;
   fetch_req_s  req;
   fetch_rsp_s  rsp;

   // predecode loop
   logic [63:0] cur_pc;
   logic [63:0] pred_next_pc;
   rv_inst_u    cur_inst;

   inst_mem u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .arvalid    (arvalid),
      .req        (req),
      .arready    (arready),
      .rvalid     (rvalid),
      .rsp        (rsp)
   );

   fetch_unit u_fetch (
      .clk          (clk),
      .rst_n        (rst_n),
      .hold         (hold),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .arready      (arready),
      .rvalid       (rvalid),
      .rsp          (rsp),
      .pred_next_pc (pred_next_pc),
      .arvalid      (arvalid),
      .req          (req),
      .cur_pc       (cur_pc),
      .cur_inst     (cur_inst),
      .out_valid    (out_valid),
      .out          (out)
   );

   // combinational, same cycle as the response
   branch_predecode u_pred (
      .cur_pc       (cur_pc),
      .cur_inst     (cur_inst),
      .pred_next_pc (pred_next_pc)
   );

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  hold,
   input  logic                  redirect,
   input  logic [63:0]           redirect_pc,
   input  logic                  arready,
   input  logic                  rvalid,
   input  fetch_pkg::fetch_rsp_s rsp,
   input  logic [63:0]           pred_next_pc,
   output logic                  arvalid,
   output fetch_pkg::fetch_req_s req,
   output logic [63:0]           cur_pc,
   output fetch_pkg::rv_inst_u   cur_inst,
   output logic                  out_valid,
   output fetch_pkg::fetch_out_s out
);
   import fetch_pkg::*;

   // pc of the request on the bus or in flight, next fetch pc when idle
   logic [63:0] pc_q;
   logic [63:0] pc_d;
   logic        outstanding;
   logic        discard;
   logic        halted;
   // redirect seen but not issued yet
   logic        redir_pend;
   logic [63:0] redir_pc_q;

   logic        accept;
   logic        drop;
   logic        rsp_ok;
   logic        rsp_err;
   logic        issue;
   logic        in_flight_d;
   fetch_out_s  out_d;

   assign accept      = arvalid && arready;
   // a redirect on the response edge also kills that read
   assign drop        = discard || redirect;
   assign rsp_ok      = rvalid && !drop;
   assign rsp_err     = rsp_ok && (rsp.rresp != `RESP_OKAY);
   // new request once the bus is free and nothing blocks
   assign issue       = !arvalid && (!outstanding || rvalid) && !hold && !halted && !rsp_err;
   assign in_flight_d = accept || (outstanding && !rvalid);

   assign req.araddr  = pc_q[31:0];
   assign cur_pc      = pc_q;
   // half select by address bit 2
   assign cur_inst.raw = pc_q[2] ? rsp.rdata[63:32] : rsp.rdata[31:0];

   always_comb begin
      out_d.pc      = pc_q;
      out_d.inst    = cur_inst;
      out_d.next_pc = pred_next_pc;
      out_d.fault   = (rsp.rresp != `RESP_OKAY);
   end

   // prediction first, redirect wins at issue
   always_comb begin
      pc_d = pc_q;
      if (rsp_ok) begin
         pc_d = pred_next_pc;
      end
      if (issue) begin
         if (redirect) begin
            pc_d = redirect_pc;
         end else if (redir_pend) begin
            pc_d = redir_pc_q;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q        <= `RESET_PC;
         // first request goes out right after reset
         arvalid     <= 1'b1;
         outstanding <= 1'b0;
         discard     <= 1'b0;
         halted      <= 1'b0;
         redir_pend  <= 1'b0;
         out_valid   <= 1'b0;
         out         <= '0;
      end else begin
         pc_q        <= pc_d;
         outstanding <= in_flight_d;
         // stale request stays marked until its response passes
         discard     <= in_flight_d && (discard || redirect || redir_pend);
         arvalid     <= issue || (arvalid && !arready);
         if (rsp_err) begin
            halted <= 1'b1;
         end
         if (issue) begin
            redir_pend <= 1'b0;
         end else if (redirect) begin
            redir_pend <= 1'b1;
         end
         out_valid <= rsp_ok;
         if (rsp_ok) begin
            out <= out_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (redirect) begin
         redir_pc_q <= redirect_pc;
      end
   end

endmodule

`default_nettype wire

/* inst_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module inst_mem (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load_valid,
   input  logic [7:0]            load_addr,
   input  logic [63:0]           load_data,
   input  logic                  arvalid,
   input  fetch_pkg::fetch_req_s req,
   output logic                  arready,
   output logic                  rvalid,
   output fetch_pkg::fetch_rsp_s rsp
);

   logic [63:0] mem [`IMEM_WORDS];

   // one read in flight at most
   logic        busy;
   logic [3:0]  lat_cnt;
   logic        fire;
   logic        accept;

   // captured request address
   logic [31:0] rd_addr;
   logic [31:0] rd_off;
   logic        rd_bad;
   logic [$clog2(`IMEM_WORDS)-1:0] rd_word;

   assign arready = ~busy;
   assign accept  = arvalid && arready;
   // counter ran out, response goes out on this edge
   assign fire    = busy && (lat_cnt == 4'd0);

   // offset from image base, wraps high for addresses below it
   assign rd_off  = rd_addr - 32'(`RESET_PC);
   assign rd_word = rd_off[$clog2(`IMEM_WORDS)+2:3];
   // outside the image or not 4-byte aligned
   assign rd_bad  = (rd_off >= 32'(`IMEM_WORDS * 8)) || (rd_addr[1:0] != 2'b00);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         lat_cnt <= '0;
         rvalid  <= 1'b0;
      end else begin
         // single-cycle strobe
         rvalid <= fire;
         if (accept) begin
            busy    <= 1'b1;
            lat_cnt <= 4'(`IMEM_LATENCY - 1);
         end else if (fire) begin
            busy <= 1'b0;
         end else if (busy) begin
            lat_cnt <= lat_cnt - 4'd1;
         end
      end
   end

   // array, address and response data
   always_ff @(posedge clk) begin
      if (load_valid) begin
         mem[load_addr] <= load_data;
      end
      if (accept) begin
         rd_addr <= req.araddr;
      end
      if (fire) begin
         if (rd_bad) begin
            rsp.rdata <= '0;
            rsp.rresp <= `RESP_SLVERR;
         end else begin
            rsp.rdata <= mem[rd_word];
            rsp.rresp <= `RESP_OKAY;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
fetch_pkg.sv
inst_mem.sv
fetch_unit.sv
branch_predecode.sv
fetch_top.sv
fetch_asserts.sv
fetch_tb.sv
